/* Makefile */
VERILATOR ?= verilator
TOP ?= lcdPanelTopTb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
FAIL_MSG ?= TEST RESULT: FAIL

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FLIST)))
DATA := tests/lcdPanelTop_testdata.txt

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN) $(DATA)
	@status=0; $(SIM_BIN) > $(LOG) 2>&1 || status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
verilog/lcdTimingPkg.sv
verilog/colorPkg.sv
verilog/lcdTiming.sv
verilog/colorBarGen.sv
verilog/ledCycler.sv
verilog/lcdPanelTop.sv
tests/lcdPanelTop_checker.sv
tests/lcdPanelTop_tb.sv

/* tests/lcdPanelTop_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module lcdPanelTopChecker
(
	input wire CLK_SYS,
	input wire rst,
	input wire lcdHsync,
	input wire lcdVsync,
	input wire lcdDen,
	input wire [colorPkg::redWidth-1:0] lcdR,
	input wire [colorPkg::greenWidth-1:0] lcdG,
	input wire [colorPkg::blueWidth-1:0] lcdB,
	input wire [2:0] led
);

	int failCount = 0;

	// the sync pulses sit in the porches and never in the active area
	denOutsideSync: assert property (@(posedge CLK_SYS) disable iff (!rst)
		lcdDen |-> (lcdHsync && lcdVsync))
	else
	begin
		failCount++;
		$error("lcdDen is high during a sync pulse");
	end

	rgbBlankOutsideDen: assert property (@(posedge CLK_SYS) disable iff (!rst)
		!lcdDen |-> (lcdR == '0 && lcdG == '0 && lcdB == '0))
	else
	begin
		failCount++;
		$error("RGB is not black while lcdDen is low");
	end

	// the LEDs are active low so at least two bits stay high
	ledAtMostOneLit: assert property (@(posedge CLK_SYS) disable iff (!rst)
		$countones(led) >= 2)
	else
	begin
		failCount++;
		$error("more than one LED is lit");
	end

endmodule

bind lcdPanelTop lcdPanelTopChecker checker_i (
	.CLK_SYS(CLK_SYS),
	.rst(rst),
	.lcdHsync(lcdHsync),
	.lcdVsync(lcdVsync),
	.lcdDen(lcdDen),
	.lcdR(lcdR),
	.lcdG(lcdG),
	.lcdB(lcdB),
	.led(led)
);

`default_nettype wire

/* tests/lcdPanelTop_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lcdPanelTopTb;

	localparam int H_ACTIVE = 32;
	localparam int H_FRONT = 2;
	localparam int H_SYNC = 2;
	localparam int H_BACK = 2;
	localparam int V_ACTIVE = 8;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 1;
	localparam int V_BACK = 1;
	localparam int PIX_DIV = 4;
	localparam int LED_PERIOD = 50;
	localparam int LINE_PIXELS = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int FRAME_CYCLES = LINE_PIXELS * (V_ACTIVE + V_FRONT + V_SYNC + V_BACK) * PIX_DIV;
	localparam int RESET_CYCLES = 8;
	localparam int MAX_FRAMES = 4;
	localparam int TIMEOUT_CYCLES = 2 * (MAX_FRAMES * FRAME_CYCLES + RESET_CYCLES);
	localparam int MAX_SAMPLES = 32;

	logic CLK_SYS;
	logic rst;
	colorPkg::patternSelType patternSel;
	logic lcdClk;
	logic lcdHsync;
	logic lcdVsync;
	logic lcdDen;
	logic [colorPkg::redWidth-1:0] lcdR;
	logic [colorPkg::greenWidth-1:0] lcdG;
	logic [colorPkg::blueWidth-1:0] lcdB;
	logic [2:0] led;

	// each sample takes six bytes for pattern, x, y, red, green and blue
	logic [7:0] testData [6*MAX_SAMPLES];
	int sampleGroup [MAX_SAMPLES];
	colorPkg::patternSelType groupPat [MAX_FRAMES];
	int nSamples = 0;
	int nGroups = 0;
	int nextSample = 0;
	int checks = 0;
	int errors = 0;
	int cycleCount = 0;
	int frameIdx = 0;
	int trackX = 0;
	int trackY = 0;
	int denRun = 0;
	int denLines = 0;
	int hsLow = 0;
	int vsLow = 0;
	int clkPhase = 0;
	logic prevVsync = 1'b1;
	logic prevDen = 1'b0;
	logic [2:0] prevLed = 3'b111;
	colorPkg::ledStateType expState = 2'd0;
	int ledSteps = 0;
	int ledHold = 0;

	lcdPanelTop #(
		.H_ACTIVE(H_ACTIVE),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK),
		.PIX_DIV(PIX_DIV),
		.LED_PERIOD(LED_PERIOD)
	) dut_i (.*);

	task automatic compareColor(
		input logic [colorPkg::redWidth-1:0] gotR,
		input logic [colorPkg::greenWidth-1:0] gotG,
		input logic [colorPkg::blueWidth-1:0] gotB,
		input logic [colorPkg::redWidth-1:0] expR,
		input logic [colorPkg::greenWidth-1:0] expG,
		input logic [colorPkg::blueWidth-1:0] expB
	);
		checks++;
		if ({gotR, gotG, gotB} !== {expR, expG, expB})
		begin
			$display("Error at %0d ns: lcdR/lcdG/lcdB = %h/%h/%h, expected %h/%h/%h at x %0d y %0d",
				$time, gotR, gotG, gotB, expR, expG, expB, trackX, trackY);
			errors++;
		end
	endtask

	task automatic compareLed(input logic [2:0] got, input logic [2:0] exp, input string name);
		checks++;
		if (got !== exp)
		begin
			$display("Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compareLevel(input logic got, input logic exp, input string name);
		checks++;
		if (got !== exp)
		begin
			$display("Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compareCount(input int got, input int exp, input string name);
		checks++;
		if (got != exp)
		begin
			$display("Error at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	// the LEDs are active low and state 1 lights bit 0, state 2 bit 1 and state 3 bit 2
	function automatic logic [2:0] ledPattern(input colorPkg::ledStateType s);
		case (s)
			2'd1: return 3'b110;
			2'd2: return 3'b101;
			2'd3: return 3'b011;
			default: return 3'b111;
		endcase
	endfunction

	// consecutive lines with the same pattern make up one frame
	task automatic loadSamples();
		colorPkg::patternSelType pat;
		for (int i = 0; i < 6 * MAX_SAMPLES; i++)
			testData[i] = 8'hFF;
		$readmemh("tests/lcdPanelTop_testdata.txt", testData);
		while (nSamples < MAX_SAMPLES && testData[6*nSamples] != 8'hFF)
		begin
			pat = colorPkg::patternSelType'(testData[6*nSamples][1:0]);
			if (nGroups == 0 || pat != groupPat[nGroups-1])
			begin
				if (nGroups == MAX_FRAMES)
				begin
					$display("the data file asks for more frames than the run allows");
					errors++;
					break;
				end
				groupPat[nGroups] = pat;
				nGroups++;
			end
			sampleGroup[nSamples] = nGroups - 1;
			nSamples++;
		end
		if (nSamples == 0)
		begin
			$display("no sample pixels were found in the data file");
			errors++;
		end
	endtask

	task automatic printCounts();
		$display("checks %0d, errors %0d", checks, errors);
	endtask

	task automatic finishRun();
		if (nextSample != nSamples)
		begin
			$display("only %0d of %0d sample pixels were reached", nextSample, nSamples);
			errors++;
		end
		if (ledSteps < 4)
		begin
			$display("the LEDs did not step through all four states");
			errors++;
		end
		if (dut_i.checker_i.failCount != 0)
		begin
			$display("the bound checker reported %0d assertion failures",
				dut_i.checker_i.failCount);
			errors += dut_i.checker_i.failCount;
		end
		printCounts();
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	endtask

	initial
	begin
		CLK_SYS = 1'b0;
		forever
			#20 CLK_SYS = ~CLK_SYS;
	end

	initial
	begin
		rst = 1'b0;
		patternSel = colorPkg::patBars;
		loadSamples();
		if (nGroups > 0)
			patternSel = groupPat[0];
		repeat (RESET_CYCLES / 2) @(posedge CLK_SYS);
		@(negedge CLK_SYS);
		compareLevel(lcdDen, 1'b0, "lcdDen");
		compareLevel(lcdHsync, 1'b1, "lcdHsync");
		compareLevel(lcdVsync, 1'b1, "lcdVsync");
		compareColor(lcdR, lcdG, lcdB, '0, '0, '0);
		compareLed(led, 3'b111, "led");
		repeat (RESET_CYCLES / 2) @(posedge CLK_SYS);
		#1;
		rst = 1'b1;
		for (int g = 1; g <= nGroups; g++)
		begin
			while (frameIdx < g)
			begin
				@(posedge CLK_SYS);
				#1;
			end
			// the next pattern goes in during vertical blanking
			if (g < nGroups)
				patternSel = groupPat[g];
		end
		finishRun();
	end

	always @(posedge CLK_SYS)
	begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, frame %0d never ended", cycleCount, frameIdx);
			printCounts();
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// lcdClk rises mid-pixel while sync, DEN and RGB are stable
	always @(posedge lcdClk)
	begin
		if (!lcdVsync && prevVsync)
		begin
			compareCount(denLines, V_ACTIVE, "DEN lines per frame");
			denLines = 0;
			trackX = 0;
			trackY = 0;
			frameIdx++;
		end
		if (!lcdVsync)
			vsLow++;
		else if (vsLow != 0)
		begin
			compareCount(vsLow, V_SYNC * LINE_PIXELS, "VSYNC low pixels");
			vsLow = 0;
		end
		if (!lcdHsync)
			hsLow++;
		else if (hsLow != 0)
		begin
			compareCount(hsLow, H_SYNC, "HSYNC low pixels");
			hsLow = 0;
		end
		if (lcdDen)
		begin
			if (!prevDen)
				denLines++;
			denRun++;
			if (nextSample < nSamples && sampleGroup[nextSample] == frameIdx
				&& int'(testData[6*nextSample+1]) == trackX
				&& int'(testData[6*nextSample+2]) == trackY)
			begin
				compareColor(lcdR, lcdG, lcdB,
					testData[6*nextSample+3][colorPkg::redWidth-1:0],
					testData[6*nextSample+4][colorPkg::greenWidth-1:0],
					testData[6*nextSample+5][colorPkg::blueWidth-1:0]);
				nextSample++;
			end
			trackX++;
			if (trackX == H_ACTIVE)
			begin
				trackX = 0;
				trackY++;
			end
		end
		else if (prevDen)
		begin
			compareCount(denRun, H_ACTIVE, "DEN pixels per line");
			denRun = 0;
		end
		prevVsync = lcdVsync;
		prevDen = lcdDen;
	end

	// pixel windows start at reset release and lcdClk is high in the second half of each
	always @(negedge CLK_SYS)
	begin
		if (rst)
		begin
			compareLevel(lcdClk, clkPhase >= PIX_DIV / 2, "lcdClk");
			clkPhase = (clkPhase + 1) % PIX_DIV;
		end
	end

	// the first hold starts at reset release and only later holds are timed
	always @(negedge CLK_SYS)
	begin
		if (rst)
		begin
			if (led != prevLed)
			begin
				expState = expState + 2'd1;
				compareLed(led, ledPattern(expState), "led");
				if (ledSteps > 0)
					compareCount(ledHold, LED_PERIOD, "LED state length in cycles");
				ledSteps++;
				ledHold = 1;
				prevLed = led;
			end
			else
				ledHold++;
		end
	end

endmodule

`default_nettype wire

/* tests/lcdPanelTop_testdata.txt */
// columns: pattern x y red green blue, all hex, one sampled pixel per line
// lines with the same pattern form one frame, pixels in raster order
00 00 00 1f 3f 1f
00 05 01 1f 3f 00
00 0a 02 00 3f 1f
00 0f 03 00 3f 00
00 10 04 1f 00 1f
00 17 05 1f 00 00
00 18 06 00 00 1f
00 1f 07 00 00 00
01 00 00 1f 3f 1f
01 10 03 1f 3f 1f
01 07 04 00 00 00
01 1f 07 00 00 00
02 09 03 01 03 00
02 14 05 02 05 00
02 1f 07 03 07 00
03 10 04 00 00 00

/* verilog/colorBarGen.sv */
`timescale 1ns/1ps
`default_nettype none

module colorBarGen
#(
	parameter int H_ACTIVE = lcdTimingPkg::H_ACTIVE
)
(
	input wire CLK_SYS,
	input wire rst,
	input wire pixEn,
	input wire lcdTimingPkg::coordType pixX,
	input wire lcdTimingPkg::coordType pixY,
	input wire inActive,
	input wire colorPkg::patternSelType patternSel,
	output logic [colorPkg::redWidth-1:0] lcdR,
	output logic [colorPkg::greenWidth-1:0] lcdG,
	output logic [colorPkg::blueWidth-1:0] lcdB
);

	typedef logic [7:0][lcdTimingPkg::coordWidth-1:0] boundType;

	// bar k starts at the first x where x*8/H_ACTIVE reaches k
	function automatic boundType calcBounds();
		boundType b;
		for (int k = 0; k < 8; k++)
			b[k] = lcdTimingPkg::coordType'((k * H_ACTIVE + 7) / 8);
		return b;
	endfunction

	localparam boundType BAR_BOUND = calcBounds();

	logic [2:0] barIdx;
	logic [colorPkg::redWidth-1:0] nextR;
	logic [colorPkg::greenWidth-1:0] nextG;
	logic [colorPkg::blueWidth-1:0] nextB;

	always_comb
	begin
		barIdx = 3'd0;
		for (int k = 1; k < 8; k++)
			if (pixX >= BAR_BOUND[k])
				barIdx = 3'(k);
	end

	always_comb
	begin
		{nextR, nextG, nextB} = '0;
		if (inActive)
		begin
			case (patternSel)
				colorPkg::patBars:
					{nextR, nextG, nextB} = colorPkg::barTable[barIdx];
				colorPkg::patGrid:
					if ((pixX[3:0] == 4'd0) || (pixY[3:0] == 4'd0))
						{nextR, nextG, nextB} = '1;
				colorPkg::patGradient:
				begin
					nextR = pixX[7 -: colorPkg::redWidth];
					nextG = pixY[colorPkg::greenWidth-1:0];
				end
				default:
					{nextR, nextG, nextB} = '0;
			endcase
		end
	end

	always_ff @(posedge CLK_SYS or negedge rst)
	begin
		if (!rst)
		begin
			lcdR <= '0;
			lcdG <= '0;
			lcdB <= '0;
		end
		else if (pixEn)
		begin
			lcdR <= nextR;
			lcdG <= nextG;
			lcdB <= nextB;
		end
	end

endmodule

`default_nettype wire

/* verilog/colorPkg.sv */
`default_nettype none

package colorPkg;

	// RGB565 field widths
	localparam int redWidth = 5;
	localparam int greenWidth = 6;
	localparam int blueWidth = 5;

	// code 3 is not named and shows black
	typedef enum logic [1:0]
	{
		patBars = 2'd0,
		patGrid = 2'd1,
		patGradient = 2'd2
	} patternSelType;

	// bar colours left to right, packed as {R, G, B}
	localparam logic [redWidth+greenWidth+blueWidth-1:0] barTable [8] = '{
		16'hFFFF,
		16'hFFE0,
		16'h07FF,
		16'h07E0,
		16'hF81F,
		16'hF800,
		16'h001F,
		16'h0000
	};

	typedef logic [1:0] ledStateType;

endpackage

`default_nettype wire

/* verilog/lcdPanelTop.sv */
`timescale 1ns/1ps
`default_nettype none

module lcdPanelTop
#(
	parameter int H_ACTIVE = lcdTimingPkg::H_ACTIVE,
	parameter int H_FRONT = lcdTimingPkg::H_FRONT,
	parameter int H_SYNC = lcdTimingPkg::H_SYNC,
	parameter int H_BACK = lcdTimingPkg::H_BACK,
	parameter int V_ACTIVE = lcdTimingPkg::V_ACTIVE,
	parameter int V_FRONT = lcdTimingPkg::V_FRONT,
	parameter int V_SYNC = lcdTimingPkg::V_SYNC,
	parameter int V_BACK = lcdTimingPkg::V_BACK,
	parameter int PIX_DIV = lcdTimingPkg::PIX_DIV_DEFAULT,
	parameter int LED_PERIOD = 12000000
)
(
	input wire CLK_SYS,
	input wire rst,
	input wire colorPkg::patternSelType patternSel,
	output logic lcdClk,
	output logic lcdHsync,
	output logic lcdVsync,
	output logic lcdDen,
	output logic [colorPkg::redWidth-1:0] lcdR,
	output logic [colorPkg::greenWidth-1:0] lcdG,
	output logic [colorPkg::blueWidth-1:0] lcdB,
	output logic [2:0] led
);

	logic pixEn;
	lcdTimingPkg::coordType pixX;
	lcdTimingPkg::coordType pixY;
	logic inActive;

	lcdTiming #(
		.H_ACTIVE(H_ACTIVE),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK),
		.PIX_DIV(PIX_DIV)
	) timing_i (
		.CLK_SYS(CLK_SYS),
		.rst(rst),
		.pixEn(pixEn),
		.pixX(pixX),
		.pixY(pixY),
		.inActive(inActive),
		.lcdClk(lcdClk),
		.lcdHsync(lcdHsync),
		.lcdVsync(lcdVsync),
		.lcdDen(lcdDen)
	);

	colorBarGen #(
		.H_ACTIVE(H_ACTIVE)
	) pattern_i (
		.CLK_SYS(CLK_SYS),
		.rst(rst),
		.pixEn(pixEn),
		.pixX(pixX),
		.pixY(pixY),
		.inActive(inActive),
		.patternSel(patternSel),
		.lcdR(lcdR),
		.lcdG(lcdG),
		.lcdB(lcdB)
	);

	ledCycler #(
		.LED_PERIOD(LED_PERIOD)
	) leds_i (
		.CLK_SYS(CLK_SYS),
		.rst(rst),
		.led(led)
	);

endmodule

`default_nettype wire

/* verilog/lcdTiming.sv */
`timescale 1ns/1ps
`default_nettype none

module lcdTiming
#(
	parameter int H_ACTIVE = lcdTimingPkg::H_ACTIVE,
	parameter int H_FRONT = lcdTimingPkg::H_FRONT,
	parameter int H_SYNC = lcdTimingPkg::H_SYNC,
	parameter int H_BACK = lcdTimingPkg::H_BACK,
	parameter int V_ACTIVE = lcdTimingPkg::V_ACTIVE,
	parameter int V_FRONT = lcdTimingPkg::V_FRONT,
	parameter int V_SYNC = lcdTimingPkg::V_SYNC,
	parameter int V_BACK = lcdTimingPkg::V_BACK,
	parameter int PIX_DIV = lcdTimingPkg::PIX_DIV_DEFAULT
)
(
	input wire CLK_SYS,
	input wire rst,
	output logic pixEn,
	output lcdTimingPkg::coordType pixX,
	output lcdTimingPkg::coordType pixY,
	output logic inActive,
	output logic lcdClk,
	output logic lcdHsync,
	output logic lcdVsync,
	output logic lcdDen
);

	localparam int DIV_WIDTH = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;
	localparam logic [DIV_WIDTH-1:0] DIV_LAST = DIV_WIDTH'(PIX_DIV - 1);
	localparam logic [DIV_WIDTH-1:0] DIV_HALF = DIV_WIDTH'(PIX_DIV / 2);

	localparam lcdTimingPkg::coordType H_ACT = lcdTimingPkg::coordType'(H_ACTIVE);
	localparam lcdTimingPkg::coordType H_SYNC_START =
		lcdTimingPkg::coordType'(H_ACTIVE + H_FRONT);
	localparam lcdTimingPkg::coordType H_SYNC_END =
		lcdTimingPkg::coordType'(H_ACTIVE + H_FRONT + H_SYNC);
	localparam lcdTimingPkg::coordType H_LAST =
		lcdTimingPkg::coordType'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);

	localparam lcdTimingPkg::coordType V_ACT = lcdTimingPkg::coordType'(V_ACTIVE);
	localparam lcdTimingPkg::coordType V_SYNC_START =
		lcdTimingPkg::coordType'(V_ACTIVE + V_FRONT);
	localparam lcdTimingPkg::coordType V_SYNC_END =
		lcdTimingPkg::coordType'(V_ACTIVE + V_FRONT + V_SYNC);
	localparam lcdTimingPkg::coordType V_LAST =
		lcdTimingPkg::coordType'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);

	logic [DIV_WIDTH-1:0] divCnt;
	logic [DIV_WIDTH-1:0] divNext;
	lcdTimingPkg::coordType xCnt;
	lcdTimingPkg::coordType yCnt;
	logic hSyncNow;
	logic vSyncNow;

	assign pixEn = (divCnt == DIV_LAST);
	assign divNext = pixEn ? '0 : divCnt + 1'b1;

	// lcdClk follows the next divider count so it rises halfway through the pixel
	always_ff @(posedge CLK_SYS or negedge rst)
	begin
		if (!rst)
		begin
			divCnt <= '0;
			lcdClk <= 1'b0;
		end
		else
		begin
			divCnt <= divNext;
			lcdClk <= (divNext >= DIV_HALF);
		end
	end

	always_ff @(posedge CLK_SYS or negedge rst)
	begin
		if (!rst)
		begin
			xCnt <= '0;
			yCnt <= '0;
		end
		else if (pixEn)
		begin
			if (xCnt == H_LAST)
			begin
				xCnt <= '0;
				if (yCnt == V_LAST)
					yCnt <= '0;
				else
					yCnt <= yCnt + 1'b1;
			end
			else
				xCnt <= xCnt + 1'b1;
		end
	end

	assign pixX = xCnt;
	assign pixY = yCnt;
	assign inActive = (xCnt < H_ACT) && (yCnt < V_ACT);
	assign hSyncNow = (xCnt >= H_SYNC_START) && (xCnt < H_SYNC_END);
	assign vSyncNow = (yCnt >= V_SYNC_START) && (yCnt < V_SYNC_END);

	// same strobe as the colour register, so control and RGB stay aligned
	always_ff @(posedge CLK_SYS or negedge rst)
	begin
		if (!rst)
		begin
			lcdHsync <= 1'b1;
			lcdVsync <= 1'b1;
			lcdDen <= 1'b0;
		end
		else if (pixEn)
		begin
			lcdHsync <= !hSyncNow;
			lcdVsync <= !vSyncNow;
			lcdDen <= inActive;
		end
	end

endmodule

`default_nettype wire

/* verilog/lcdTimingPkg.sv */
`default_nettype none

package lcdTimingPkg;

	// width of the pixel and line counters
	localparam int coordWidth = 11;

	// horizontal timing in pixels
	localparam int H_ACTIVE = 480;
	localparam int H_FRONT = 8;
	localparam int H_SYNC = 4;
	localparam int H_BACK = 43;

	// vertical timing in lines
	localparam int V_ACTIVE = 272;
	localparam int V_FRONT = 8;
	localparam int V_SYNC = 4;
	localparam int V_BACK = 12;

	// system clocks per pixel, 90 MHz down to a 9 MHz pixel rate
	localparam int PIX_DIV_DEFAULT = 10;

	typedef logic [coordWidth-1:0] coordType;

endpackage

`default_nettype wire

/* verilog/ledCycler.sv */
`timescale 1ns/1ps
`default_nettype none

module ledCycler
#(
	parameter int LED_PERIOD = 12000000
)
(
	input wire CLK_SYS,
	input wire rst,
	output logic [2:0] led
);

	localparam int CNT_WIDTH = (LED_PERIOD > 1) ? $clog2(LED_PERIOD) : 1;
	localparam logic [CNT_WIDTH-1:0] CNT_LAST = CNT_WIDTH'(LED_PERIOD - 1);

	logic [CNT_WIDTH-1:0] periodCnt;
	colorPkg::ledStateType ledState;

	// state steps once per full period and wraps from 3 back to all off
	always_ff @(posedge CLK_SYS or negedge rst)
	begin
		if (!rst)
		begin
			periodCnt <= '0;
			ledState <= '0;
		end
		else if (periodCnt == CNT_LAST)
		begin
			periodCnt <= '0;
			ledState <= ledState + 1'b1;
		end
		else
			periodCnt <= periodCnt + 1'b1;
	end

	// LEDs are active low, so only the lit colour is pulled down
	assign led[0] = !(ledState == 2'd1);
	assign led[1] = !(ledState == 2'd2);
	assign led[2] = !(ledState == 2'd3);

endmodule

`default_nettype wire
